// File: sources.f
+incdir+include
source/ex_pkg.sv
source/ex_sequencer.sv
source/ex_alu.sv
source/ex_mdu.sv
source/ex_top.sv
dv/ex_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Expected result of a base operation
function automatic logic [31:0] ref_alu(ex_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b);
  logic [31:0] res;
  case (op)
    ex_pkg::ADD:  res = a + b;
    ex_pkg::SUB:  res = a - b;
    ex_pkg::AND:  res = a & b;
    ex_pkg::OR:   res = a | b;
    ex_pkg::XOR:  res = a ^ b;
    ex_pkg::SLT:  res = {31'h0, $signed(a) < $signed(b)};
    ex_pkg::SLTU: res = {31'h0, a < b};
    default:      res = a + b;
  endcase
  return res;
endfunction

// Expected RV32M result from 64-bit arithmetic
// Signed overflow of div and rem falls out of the wide division
function automatic logic [31:0] ref_mdu(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic [63:0]        ua;
  logic [63:0]        ub;
  logic [63:0]        wide;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ua = {32'h0, a};
  ub = {32'h0, b};
  case (f3)
    ex_pkg::F3_MUL:    wide = ua * ub;
    ex_pkg::F3_MULH:   wide = (sa * sb) >> 32;
    ex_pkg::F3_MULHSU: wide = (sa * ub) >> 32;
    ex_pkg::F3_MULHU:  wide = (ua * ub) >> 32;
    ex_pkg::F3_DIV:    wide = (b == 32'h0) ? -64'sd1 : sa / sb;
    ex_pkg::F3_DIVU:   wide = (b == 32'h0) ? 64'hffff_ffff : ua / ub;
    ex_pkg::F3_REM:    wide = (b == 32'h0) ? sa : sa % sb;
    ex_pkg::F3_REMU:   wide = (b == 32'h0) ? ua : ua % ub;
    default:           wide = 64'h0;
  endcase
  return wide[31:0];
endfunction

// Expected result of any request
function automatic logic [31:0] ref_result(logic m_ext, ex_pkg::alu_op_e op, logic [2:0] f3,
                                           logic [31:0] a, logic [31:0] b);
  return m_ext ? ref_mdu(f3, a, b) : ref_alu(op, a, b);
endfunction

`endif

// File: dv/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;

  logic            clock;
  logic            reset;
  logic            in_valid;
  logic            m_ext;
  ex_pkg::alu_op_e alu_op;
  logic [2:0]      funct3;
  logic [31:0]     operand_a;
  logic [31:0]     operand_b;
  logic            out_ready;
  logic            in_ready;
  logic            out_valid;
  logic [31:0]     result;

  // Request waiting to be offered on the next falling edge
  logic            req_pending;
  logic            req_m;
  ex_pkg::alu_op_e req_op;
  logic [2:0]      req_f3;
  logic [31:0]     req_a;
  logic [31:0]     req_b;
  logic            accepted;
  logic            held;
  logic [31:0]     held_value;
  logic [31:0]     exp_q[$];
  int              stall_pct;
  int              checks;
  int              errors;
  int              test_checks;
  int              test_errors;

  `include "ex_ref_model.svh"

  ex_top uut (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .m_ext     (m_ext),
    .alu_op    (alu_op),
    .funct3    (funct3),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .result    (result)
  );

  always #20 clock = ~clock;

  // Operands lean toward the values that hit corner cases
  function automatic logic [31:0] rand_operand();
    logic [31:0] v;
    case ($urandom_range(7))
      0: v = 32'h0;
      1: v = 32'h1;
      2: v = 32'hffff_ffff;
      3: v = 32'h8000_0000;
      default: v = $urandom;
    endcase
    return v;
  endfunction

  function automatic ex_pkg::alu_op_e rand_alu_op();
    return ex_pkg::alu_op_e'(3'($urandom_range(6)));
  endfunction

  // One falling edge: drive inputs, then look at the settled outputs
  task automatic tick();
    logic [31:0] exp;
    @(negedge clock);
    in_valid  = req_pending;
    m_ext     = req_m;
    alu_op    = req_op;
    funct3    = req_f3;
    operand_a = req_a;
    operand_b = req_b;
    out_ready = ($urandom_range(99) >= stall_pct);
    #1;
    if (held) begin
      checks++;
      assert (out_valid) else begin
        $display("out_valid dropped while the result was stalled");
        errors++;
      end
      assert (result == held_value) else begin
        $display("[FAIL] result expected %h got %h", held_value, result);
        errors++;
      end
      held = 1'b0;
    end
    if (out_valid && !out_ready) begin
      held       = 1'b1;
      held_value = result;
      checks++;
      assert (!in_ready) else begin
        $display("in_ready is high while a result waits");
        errors++;
      end
    end
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("a result arrived with no request outstanding");
        errors++;
      end else begin
        exp = exp_q.pop_front();
        checks++;
        assert (result == exp) else begin
          $display("[FAIL] result expected %h got %h", exp, result);
          errors++;
        end
      end
    end
    if (in_valid && in_ready) begin
      exp_q.push_back(ref_result(req_m, req_op, req_f3, req_a, req_b));
      req_pending = 1'b0;
      accepted    = 1'b1;
    end
  endtask

  task automatic send(logic m, ex_pkg::alu_op_e op, logic [2:0] f3,
                      logic [31:0] a, logic [31:0] b);
    int n;
    req_m       = m;
    req_op      = op;
    req_f3      = f3;
    req_a       = a;
    req_b       = b;
    req_pending = 1'b1;
    accepted    = 1'b0;
    n           = 0;
    while (!accepted && n < 100) begin
      tick();
      n++;
    end
    if (!accepted) begin
      $display("request was not accepted within 100 cycles");
      errors++;
      req_pending = 1'b0;
    end
  endtask

  // Wait until every accepted request has returned its result
  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 100) begin
      tick();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("no result arrived within 100 cycles");
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic report_test(string name);
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
  endtask

  task automatic check_reset_and_latency();
    int k;
    begin_test();
    stall_pct = 0;
    tick();
    checks++;
    assert (in_ready && !out_valid) else begin
      $display("in_ready or out_valid is wrong after reset");
      errors++;
    end
    for (int i = 0; i < 20; i++) begin
      send(1'b0, rand_alu_op(), 3'h0, rand_operand(), rand_operand());
      k = 0;
      while (!out_valid && k < 100) begin
        tick();
        k++;
      end
      checks++;
      // Accept tick, one tick with out_valid low, then the result
      assert (k == 2) else begin
        $display("[FAIL] out_valid latency expected %h got %h", 2, k);
        errors++;
      end
      drain();
    end
    report_test("reset and base latency");
  endtask

  task automatic run_mdu_group(string name, logic [2:0] f3_base, int count);
    logic [31:0] b;
    begin_test();
    stall_pct = 20;
    for (int i = 0; i < count; i++) begin
      b = ($urandom_range(3) == 0) ? 32'($urandom_range(15)) : rand_operand();
      send(1'b1, ex_pkg::ADD, f3_base | 3'($urandom_range(3)), rand_operand(), b);
    end
    drain();
    report_test(name);
  endtask

  task automatic run_corner_cases();
    begin_test();
    stall_pct = 20;
    for (int f = 4; f < 8; f++) begin
      send(1'b1, ex_pkg::ADD, 3'(f), rand_operand(), 32'h0);
      send(1'b1, ex_pkg::ADD, 3'(f), 32'h8000_0000, 32'h0);
      send(1'b1, ex_pkg::ADD, 3'(f), 32'h0, 32'h0);
      send(1'b1, ex_pkg::ADD, 3'(f), 32'h8000_0000, 32'hffff_ffff);
    end
    drain();
    report_test("division corner cases");
  endtask

  task automatic run_stalled_traffic();
    begin_test();
    stall_pct = 60;
    for (int i = 0; i < 80; i++) begin
      if ($urandom_range(1) == 0) begin
        send(1'b0, rand_alu_op(), 3'h0, rand_operand(), rand_operand());
      end else begin
        send(1'b1, ex_pkg::ADD, 3'($urandom_range(7)), rand_operand(), rand_operand());
      end
    end
    drain();
    report_test("back-pressure");
  endtask

  // The base request waits behind the multiply/divide and then uses the adder
  task automatic run_base_after_mdu();
    begin_test();
    stall_pct = 0;
    for (int i = 0; i < 20; i++) begin
      send(1'b1, ex_pkg::ADD, 3'($urandom_range(7)), rand_operand(), rand_operand());
      send(1'b0, rand_alu_op(), 3'h0, rand_operand(), rand_operand());
    end
    drain();
    report_test("base after multiply/divide");
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    m_ext       = 1'b0;
    alu_op      = ex_pkg::ADD;
    funct3      = 3'h0;
    operand_a   = 32'h0;
    operand_b   = 32'h0;
    out_ready   = 1'b1;
    req_pending = 1'b0;
    req_m       = 1'b0;
    req_op      = ex_pkg::ADD;
    req_f3      = 3'h0;
    req_a       = 32'h0;
    req_b       = 32'h0;
    accepted    = 1'b0;
    held        = 1'b0;
    held_value  = 32'h0;
    stall_pct   = 0;
    checks      = 0;
    errors      = 0;
    void'($urandom(32'h29ad));
    repeat (5) @(negedge clock);
    reset = 1'b0;
    check_reset_and_latency();
    run_mdu_group("multiply", 3'b000, 60);
    run_mdu_group("divide", 3'b100, 60);
    run_corner_cases();
    run_stalled_traffic();
    run_base_after_mdu();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: source/ex_top.sv
`timescale 1ns/1ps

module ex_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic                    m_ext,
  input  ex_pkg::alu_op_e         alu_op,
  input  logic [2:0]              funct3,
  input  logic [ex_pkg::XLEN-1:0] operand_a,
  input  logic [ex_pkg::XLEN-1:0] operand_b,
  input  logic                    out_ready,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic [ex_pkg::XLEN-1:0] result
);

  ex_pkg::alu_op_e alu_op_q;
  ex_pkg::mdu_op_e mdu_op;
  logic [31:0]     alu_a;
  logic [31:0]     alu_b;
  logic [31:0]     alu_result;
  logic            mdu_valid;
  logic            signed_a;
  logic            signed_b;
  logic [31:0]     mdu_a;
  logic [31:0]     mdu_b;
  logic [31:0]     mdu_result;
  logic            mdu_done;
  logic [32:0]     add_a;
  logic [32:0]     add_b;
  logic [33:0]     add_sum34;
  logic [31:0]     add_sum32;
  logic            add_not_zero;

  ex_sequencer u_sequencer (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .m_ext      (m_ext),
    .alu_op     (alu_op),
    .funct3     (funct3),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .out_ready  (out_ready),
    .alu_result (alu_result),
    .mdu_done   (mdu_done),
    .mdu_result (mdu_result),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .result     (result),
    .mdu_valid  (mdu_valid),
    .mdu_op     (mdu_op),
    .signed_a   (signed_a),
    .signed_b   (signed_b),
    .mdu_a      (mdu_a),
    .mdu_b      (mdu_b),
    .alu_op_q   (alu_op_q),
    .alu_a      (alu_a),
    .alu_b      (alu_b)
  );

  // The adder follows the multiply/divide unit while it is busy
  ex_alu u_alu (
    .alu_op       (alu_op_q),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .mdu_busy     (mdu_valid),
    .add_a        (add_a),
    .add_b        (add_b),
    .alu_result   (alu_result),
    .add_sum34    (add_sum34),
    .add_sum32    (add_sum32),
    .add_not_zero (add_not_zero)
  );

  ex_mdu u_mdu (
    .clock        (clock),
    .reset        (reset),
    .mdu_valid    (mdu_valid),
    .mdu_op       (mdu_op),
    .signed_a     (signed_a),
    .signed_b     (signed_b),
    .mdu_a        (mdu_a),
    .mdu_b        (mdu_b),
    .add_sum34    (add_sum34),
    .add_sum32    (add_sum32),
    .add_not_zero (add_not_zero),
    .add_a        (add_a),
    .add_b        (add_b),
    .mdu_result   (mdu_result),
    .mdu_done     (mdu_done)
  );

endmodule

// File: source/ex_mdu.sv
`timescale 1ns/1ps

module ex_mdu (
  input  logic            clock,
  input  logic            reset,
  input  logic            mdu_valid,
  input  ex_pkg::mdu_op_e mdu_op,
  input  logic            signed_a,
  input  logic            signed_b,
  input  logic [31:0]     mdu_a,
  input  logic [31:0]     mdu_b,
  input  logic [33:0]     add_sum34,
  input  logic [31:0]     add_sum32,
  input  logic            add_not_zero,
  output logic [32:0]     add_a,
  output logic [32:0]     add_b,
  output logic [31:0]     mdu_result,
  output logic            mdu_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ABS_A,
    ST_ABS_B,
    ST_COMP,
    ST_LAST,
    ST_CHANGE_SIGN,
    ST_FINISH
  } state_e;

  state_e      state_q, state_d;
  logic [4:0]  count_q, count_d;
  logic [32:0] accum_q, accum_d;
  logic [32:0] op_a_shift_q, op_a_shift_d;
  logic [32:0] op_b_shift_q, op_b_shift_d;
  logic [31:0] numerator_q, numerator_d;
  logic [32:0] sum_low;
  logic [32:0] sum_high;
  logic        sign_a;
  logic        sign_b;
  logic [32:0] op_a_ext;
  logic [32:0] op_b_ext;
  logic [31:0] b0_mask;
  logic [32:0] pp;
  logic [32:0] pp_last;
  logic [32:0] one_shift;
  logic        greater_equal;
  logic [31:0] next_remainder;
  logic [32:0] next_quotient;
  logic        div_change_sign;
  logic        rem_change_sign;
  logic        is_mul;

  // Plain sum and sum shifted right by one
  assign sum_low  = add_sum34[32:0];
  assign sum_high = add_sum34[33:1];

  assign sign_a   = mdu_a[31] & signed_a;
  assign sign_b   = mdu_b[31] & signed_b;
  assign op_a_ext = {sign_a, mdu_a};
  assign op_b_ext = {sign_b, mdu_b};

  // Sign-corrected partial products
  assign b0_mask = {32{op_b_shift_q[0]}};
  assign pp      = {~(op_a_shift_q[32] & op_b_shift_q[0]), op_a_shift_q[31:0] & b0_mask};
  assign pp_last = {(op_a_shift_q[32] & op_b_shift_q[0]), ~(op_a_shift_q[31:0] & b0_mask)};

  // Restoring division step on the remainder minus divisor
  assign greater_equal  = (accum_q[31] == op_b_shift_q[31]) ? ~sum_high[31] : accum_q[31];
  assign one_shift      = {32'h0, 1'b1} << count_q;
  assign next_remainder = greater_equal ? sum_high[31:0] : accum_q[31:0];
  assign next_quotient  = greater_equal ? (op_a_shift_q | one_shift) : op_a_shift_q;

  assign div_change_sign = sign_a ^ sign_b;
  assign rem_change_sign = sign_a;

  // Operands for the shared ALU adder
  always_comb begin
    add_a = accum_q;
    add_b = {~op_b_shift_q[31:0], 1'b1};
    case (mdu_op)
      ex_pkg::MULL: add_b = pp;
      ex_pkg::MULH: add_b = (state_q == ST_LAST) ? pp_last : pp;
      default: begin
        case (state_q)
          // 0 - B doubles as the divide-by-zero check in idle
          ST_IDLE, ST_ABS_B: begin
            add_a = {32'h0, 1'b1};
            add_b = {~mdu_b, 1'b1};
          end
          ST_ABS_A: begin
            add_a = {32'h0, 1'b1};
            add_b = {~mdu_a, 1'b1};
          end
          ST_CHANGE_SIGN: begin
            add_a = {32'h0, 1'b1};
            add_b = {~accum_q[31:0], 1'b1};
          end
          default: begin
            add_a = {accum_q[31:0], 1'b1};
            add_b = {~op_b_shift_q[31:0], 1'b1};
          end
        endcase
      end
    endcase
  end

  always_comb begin
    state_d      = state_q;
    count_d      = count_q;
    accum_d      = accum_q;
    op_a_shift_d = op_a_shift_q;
    op_b_shift_d = op_b_shift_q;
    numerator_d  = numerator_q;
    if (mdu_valid) begin
      case (state_q)
        ST_IDLE: begin
          count_d = 5'd31;
          case (mdu_op)
            ex_pkg::MULL: begin
              op_a_shift_d = op_a_ext << 1;
              accum_d      = {~(op_a_ext[32] & mdu_b[0]), op_a_ext[31:0] & {32{mdu_b[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              // Small multipliers skip straight to the last step
              state_d      = (op_b_ext[32:1] == 32'h0) ? ST_LAST : ST_COMP;
            end
            ex_pkg::MULH: begin
              op_a_shift_d = op_a_ext;
              accum_d      = {1'b1, ~(op_a_ext[32] & mdu_b[0]),
                              op_a_ext[31:1] & {31{mdu_b[0]}}};
              op_b_shift_d = op_b_ext >> 1;
              state_d      = ST_COMP;
            end
            ex_pkg::DIV: begin
              // All ones is the quotient for a zero divisor
              accum_d = {33{1'b1}};
              state_d = add_not_zero ? ST_ABS_A : ST_FINISH;
            end
            default: begin
              // Remainder by zero is the dividend
              accum_d = op_a_ext;
              state_d = add_not_zero ? ST_ABS_A : ST_FINISH;
            end
          endcase
        end

        ST_ABS_A: begin
          op_a_shift_d = 33'h0;
          numerator_d  = sign_a ? add_sum32 : mdu_a;
          state_d      = ST_ABS_B;
        end

        ST_ABS_B: begin
          accum_d      = {32'h0, numerator_q[31]};
          op_b_shift_d = {1'b0, sign_b ? add_sum32 : mdu_b};
          state_d      = ST_COMP;
        end

        ST_COMP: begin
          count_d = count_q - 5'd1;
          case (mdu_op)
            ex_pkg::MULL: begin
              accum_d      = sum_low;
              op_a_shift_d = op_a_shift_q << 1;
              op_b_shift_d = op_b_shift_q >> 1;
              state_d      = ((op_b_shift_q[32:1] == 32'h0) || (count_q == 5'd1)) ?
                             ST_LAST : ST_COMP;
            end
            ex_pkg::MULH: begin
              accum_d      = sum_high;
              op_b_shift_d = op_b_shift_q >> 1;
              state_d      = (count_q == 5'd1) ? ST_LAST : ST_COMP;
            end
            default: begin
              accum_d      = {next_remainder, numerator_q[count_d]};
              op_a_shift_d = next_quotient;
              state_d      = (count_q == 5'd1) ? ST_LAST : ST_COMP;
            end
          endcase
        end

        ST_LAST: begin
          case (mdu_op)
            ex_pkg::DIV: begin
              accum_d = next_quotient;
              state_d = ST_CHANGE_SIGN;
            end
            ex_pkg::REM: begin
              accum_d = {1'b0, next_remainder};
              state_d = ST_CHANGE_SIGN;
            end
            // Product leaves straight from the adder
            default: state_d = ST_IDLE;
          endcase
        end

        ST_CHANGE_SIGN: begin
          state_d = ST_FINISH;
          if (mdu_op == ex_pkg::DIV && div_change_sign) begin
            accum_d = {1'b0, add_sum32};
          end else if (mdu_op == ex_pkg::REM && rem_change_sign) begin
            accum_d = {1'b0, add_sum32};
          end
        end

        ST_FINISH: state_d = ST_IDLE;

        default: state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= 5'd0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  always_ff @(posedge clock) begin
    accum_q      <= accum_d;
    op_a_shift_q <= op_a_shift_d;
    op_b_shift_q <= op_b_shift_d;
    numerator_q  <= numerator_d;
  end

  assign is_mul     = (mdu_op == ex_pkg::MULL) | (mdu_op == ex_pkg::MULH);
  assign mdu_done   = (state_q == ST_FINISH) | ((state_q == ST_LAST) & is_mul);
  assign mdu_result = is_mul ? sum_low[31:0] : accum_q[31:0];

endmodule

// File: source/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e alu_op,
  input  logic [31:0]     alu_a,
  input  logic [31:0]     alu_b,
  input  logic            mdu_busy,
  input  logic [32:0]     add_a,
  input  logic [32:0]     add_b,
  output logic [31:0]     alu_result,
  output logic [33:0]     add_sum34,
  output logic [31:0]     add_sum32,
  output logic            add_not_zero
);

  logic        is_sub;
  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic        lt_signed;
  logic        lt_unsigned;

  assign is_sub = (alu_op == ex_pkg::SUB) | (alu_op == ex_pkg::SLT) |
                  (alu_op == ex_pkg::SLTU);

  // Bit 0 carries the +1 of a two's complement subtraction
  always_comb begin
    if (mdu_busy) begin
      adder_in_a = add_a;
      adder_in_b = add_b;
    end else begin
      adder_in_a = {alu_a, 1'b1};
      adder_in_b = is_sub ? {~alu_b, 1'b1} : {alu_b, 1'b0};
    end
  end

  assign add_sum34    = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign add_sum32    = add_sum34[32:1];
  assign add_not_zero = |add_sum32;

  // No carry out of a - b means a borrow
  assign lt_unsigned = ~add_sum34[33];
  assign lt_signed   = (alu_a[31] == alu_b[31]) ? add_sum32[31] : alu_a[31];

  always_comb begin
    case (alu_op)
      ex_pkg::ADD:  alu_result = add_sum32;
      ex_pkg::SUB:  alu_result = add_sum32;
      ex_pkg::AND:  alu_result = alu_a & alu_b;
      ex_pkg::OR:   alu_result = alu_a | alu_b;
      ex_pkg::XOR:  alu_result = alu_a ^ alu_b;
      ex_pkg::SLT:  alu_result = {31'h0, lt_signed};
      ex_pkg::SLTU: alu_result = {31'h0, lt_unsigned};
      default:      alu_result = add_sum32;
    endcase
  end

endmodule

// File: source/ex_sequencer.sv
`timescale 1ns/1ps

module ex_sequencer (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  input  logic                      m_ext,
  input  ex_pkg::alu_op_e           alu_op,
  input  logic [2:0]                funct3,
  input  logic [ex_pkg::XLEN-1:0]   operand_a,
  input  logic [ex_pkg::XLEN-1:0]   operand_b,
  input  logic                      out_ready,
  input  logic [ex_pkg::XLEN-1:0]   alu_result,
  input  logic                      mdu_done,
  input  logic [ex_pkg::XLEN-1:0]   mdu_result,
  output logic                      in_ready,
  output logic                      out_valid,
  output logic [ex_pkg::XLEN-1:0]   result,
  output logic                      mdu_valid,
  output ex_pkg::mdu_op_e           mdu_op,
  output logic                      signed_a,
  output logic                      signed_b,
  output logic [ex_pkg::XLEN-1:0]   mdu_a,
  output logic [ex_pkg::XLEN-1:0]   mdu_b,
  output ex_pkg::alu_op_e           alu_op_q,
  output logic [ex_pkg::XLEN-1:0]   alu_a,
  output logic [ex_pkg::XLEN-1:0]   alu_b
);

  logic                    accept;
  logic                    capture;
  logic                    alu_pend;
  logic [ex_pkg::XLEN-1:0] operand_a_q;
  logic [ex_pkg::XLEN-1:0] operand_b_q;
  ex_pkg::mdu_op_e         dec_op;
  logic                    dec_signed_a;
  logic                    dec_signed_b;

  // Idle unit and an output register that is empty or draining
  assign in_ready = ~mdu_valid & ~alu_pend & (~out_valid | out_ready);
  assign accept   = in_valid & in_ready;
  assign capture  = alu_pend | mdu_done;

  // The same registered operands feed both units
  assign alu_a = operand_a_q;
  assign alu_b = operand_b_q;
  assign mdu_a = operand_a_q;
  assign mdu_b = operand_b_q;

  // funct3 to operation class and operand signedness
  always_comb begin
    dec_op       = ex_pkg::REM;
    dec_signed_a = 1'b0;
    dec_signed_b = 1'b0;
    case (funct3)
      ex_pkg::F3_MUL: dec_op = ex_pkg::MULL;
      ex_pkg::F3_MULH: begin
        dec_op       = ex_pkg::MULH;
        dec_signed_a = 1'b1;
        dec_signed_b = 1'b1;
      end
      ex_pkg::F3_MULHSU: begin
        dec_op       = ex_pkg::MULH;
        dec_signed_a = 1'b1;
      end
      ex_pkg::F3_MULHU: dec_op = ex_pkg::MULH;
      ex_pkg::F3_DIV: begin
        dec_op       = ex_pkg::DIV;
        dec_signed_a = 1'b1;
        dec_signed_b = 1'b1;
      end
      ex_pkg::F3_DIVU: dec_op = ex_pkg::DIV;
      ex_pkg::F3_REM: begin
        dec_op       = ex_pkg::REM;
        dec_signed_a = 1'b1;
        dec_signed_b = 1'b1;
      end
      ex_pkg::F3_REMU: dec_op = ex_pkg::REM;
      default: dec_op = ex_pkg::REM;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      operand_a_q <= operand_a;
      operand_b_q <= operand_b;
      alu_op_q    <= alu_op;
      mdu_op      <= dec_op;
      signed_a    <= dec_signed_a;
      signed_b    <= dec_signed_b;
    end
    // Base results come from the ALU in the cycle after accept
    if (capture) begin
      result <= alu_pend ? alu_result : mdu_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_pend  <= 1'b0;
      mdu_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      alu_pend <= accept & ~m_ext;
      if (accept && m_ext) begin
        mdu_valid <= 1'b1;
      end else if (mdu_done) begin
        mdu_valid <= 1'b0;
      end
      if (capture) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

endmodule

// File: source/ex_pkg.sv
package ex_pkg;

  // Data width of the execute unit
  localparam int XLEN = 32;

  // Base operations handled by the ALU alone
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLTU
  } alu_op_e;

  // Operation classes of the iterative multiply/divide unit
  // MULL returns the low product word and MULH the high word
  typedef enum logic [1:0] {
    MULL,
    MULH,
    DIV,
    REM
  } mdu_op_e;

  // RV32M funct3 encodings
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;
  localparam logic [2:0] F3_DIV    = 3'b100;
  localparam logic [2:0] F3_DIVU   = 3'b101;
  localparam logic [2:0] F3_REM    = 3'b110;
  localparam logic [2:0] F3_REMU   = 3'b111;

endpackage
